// ==== cpu_core.f ====
+incdir+.
cpu_pkg.sv
cpu_alu.sv
cpu_regfile.sv
cpu_fetch.sv
cpu_decode.sv
cpu_execute.sv
cpu_core.sv
tb_cpu_core.sv

// ==== tb_cpu_model.svh ====
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

// Random program generator and sequential reference model

logic [DATA_W-1:0] model_rf [REGNO];
logic [7:0]        jump_taken_seen;
logic [7:0]        jump_skipped_seen;

// Edge values show up often so carry and zero get exercised
function automatic logic [IMM_W-1:0] next_imm();
    int sel;
    sel = rand_below(4);
    if (sel == 0) begin
        return 16'hffff;
    end
    if (sel == 1) begin
        return IMM_W'(rand_below(3));
    end
    return IMM_W'(lcg_next() >> 12);
endfunction

task automatic gen_program();
    int                   kind;
    logic [OPC_W-1:0]     opc;
    logic [IMM_W-1:0]     imm;
    logic [REGNO_LOG-1:0] dst;
    logic [REGNO_LOG-1:0] src1;
    logic [REGNO_LOG-1:0] src2;
    logic [3:0]           cond;
    prog_len = 6 + rand_below(MAX_LEN - 5);
    for (int i = 0; i < prog_len - 2; i++) begin
        kind = rand_below(13);
        imm  = next_imm();
        dst  = REGNO_LOG'(rand_below(REGNO));
        src1 = REGNO_LOG'(rand_below(REGNO));
        src2 = REGNO_LOG'(rand_below(REGNO));
        cond = 4'(rand_below(8));
        case (kind)
            0:       opc = OPC_NOP;
            1:       opc = OPC_MOV;
            2:       opc = OPC_LDI;
            3:       opc = OPC_ADD;
            4:       opc = OPC_ADI;
            5:       opc = OPC_ADC;
            6:       opc = OPC_SUB;
            7:       opc = OPC_SUC;
            8:       opc = OPC_CMP;
            9:       opc = OPC_CMI;
            10, 11:  opc = OPC_JMP;
            default: opc = 7'h0f + 7'(rand_below(8'h70));
        endcase
        if (opc == OPC_JMP) begin
            // Forward only, at most up to the closing LDI
            imm     = IMM_W'(i + 1 + rand_below(prog_len - 2 - i));
            prog[i] = {imm, 5'd0, cond, opc};
        end else begin
            prog[i] = {imm, src2, src1, dst, opc};
        end
    end
    // Closing LDI marks the end, then a jump to itself
    prog[prog_len-2] = {next_imm(), 6'd0, dst, OPC_LDI};
    prog[prog_len-1] = {IMM_W'(prog_len - 1), 5'd0, JC_ALWAYS, OPC_JMP};
endtask

task automatic record_write(input logic [REGNO_LOG-1:0] r, input logic [DATA_W-1:0] v);
    model_rf[r] = v;
    exp_reg.push_back(r);
    exp_data.push_back(v);
endtask

task automatic run_model();
    logic [I_SIZE-1:0]    w;
    logic [OPC_W-1:0]     opc;
    logic [REGNO_LOG-1:0] d;
    logic [IMM_W-1:0]     imm;
    logic [DATA_W-1:0]    a;
    logic [DATA_W-1:0]    b;
    logic                 c;
    logic                 z;
    logic                 taken;
    int                   cond;
    int                   cin;
    int                   wide;
    int                   pc;
    exp_reg.delete();
    exp_data.delete();
    for (int r = 0; r < REGNO; r++) begin
        model_rf[r] = '0;
    end
    c  = 1'b0;
    z  = 1'b0;
    pc = 0;
    while (pc < prog_len - 1) begin
        w   = prog[pc];
        opc = w[6:0];
        d   = w[9:7];
        imm = w[31:16];
        a   = model_rf[w[12:10]];
        if (opc == OPC_ADI || opc == OPC_SUC || opc == OPC_CMI) begin
            b = imm;
        end else begin
            b = model_rf[w[15:13]];
        end
        pc = pc + 1;
        case (opc)
            OPC_MOV: record_write(d, a);
            OPC_LDI: record_write(d, imm);
            OPC_ADD, OPC_ADI, OPC_ADC: begin
                cin  = (opc == OPC_ADC) ? int'(c) : 0;
                wide = int'(a) + int'(b) + cin;
                c    = (wide > 65535);
                z    = (wide[15:0] == 16'h0000);
                record_write(d, wide[15:0]);
            end
            OPC_SUB, OPC_SUC, OPC_CMP, OPC_CMI: begin
                // Carry is set when the subtraction borrows
                cin  = (opc == OPC_SUC) ? int'(c) : 0;
                wide = int'(a) - int'(b) - cin;
                c    = (int'(a) < int'(b) + cin);
                z    = (wide[15:0] == 16'h0000);
                if (opc == OPC_SUB) begin
                    record_write(d, wide[15:0]);
                end
            end
            OPC_JMP: begin
                cond = int'(w[10:7]);
                case (cond)
                    0:       taken = 1'b1;
                    1:       taken = z;
                    2:       taken = !z;
                    3:       taken = c;
                    4:       taken = !c;
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    jump_taken_seen[cond] = 1'b1;
                    pc = int'(imm[PC_W-1:0]);
                end else begin
                    jump_skipped_seen[cond] = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end
    exp_flags = {c, z};
endtask

`endif

// ==== tb_cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core import cpu_pkg::*; ();

    localparam int NUM_PROGS   = 100;
    localparam int MAX_LEN     = 32;
    localparam int RUN_TIMEOUT = 2000;

    logic                 i_clk;
    logic                 i_rst;
    logic                 i_run;
    logic                 i_imem_we;
    logic [PC_W-1:0]      i_imem_addr;
    logic [I_SIZE-1:0]    i_imem_data;
    logic                 o_wb_valid;
    logic [REGNO_LOG-1:0] o_wb_reg;
    logic [DATA_W-1:0]    o_wb_data;
    logic [1:0]           o_flags;

    logic [31:0]          lcg_state;
    logic [I_SIZE-1:0]    prog [MAX_LEN];
    int                   prog_len;
    logic [REGNO_LOG-1:0] exp_reg [$];
    logic [DATA_W-1:0]    exp_data [$];
    logic [1:0]           exp_flags;
    int                   wb_count;
    int                   wb_errors;
    int                   flag_errors;
    int                   cov_misses;

    cpu_core dut (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_run       (i_run),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .o_wb_valid  (o_wb_valid),
        .o_wb_reg    (o_wb_reg),
        .o_wb_data   (o_wb_data),
        .o_flags     (o_flags)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'((lcg_next() >> 8) % n);
    endfunction

    `include "tb_cpu_model.svh"

    task automatic check_wb(input logic [REGNO_LOG-1:0] got_reg,
                            input logic [DATA_W-1:0]    got_data,
                            input logic [REGNO_LOG-1:0] want_reg,
                            input logic [DATA_W-1:0]    want_data);
        wb_count++;
        if (got_reg !== want_reg || got_data !== want_data) begin
            wb_errors++;
            $display("[ERROR] %0t: writeback r%0d = %04h, expected r%0d = %04h",
                     $time, got_reg, got_data, want_reg, want_data);
        end
    endtask

    task automatic check_flags(input logic [1:0] got, input logic [1:0] want, input string what);
        if (got !== want) begin
            flag_errors++;
            $display("[ERROR] %0t: flags {c,z} = %b %s, expected %b", $time, got, what, want);
        end
    endtask

    // Codes up to JC_NC can be taken, all but JC_ALWAYS can fall through
    task automatic check_jump_coverage();
        for (int c = 0; c < 8; c++) begin
            if (c <= int'(JC_NC) && !jump_taken_seen[c]) begin
                cov_misses++;
                $display("Jump code %0d was never taken by any program", c);
            end
            if (c != int'(JC_ALWAYS) && !jump_skipped_seen[c]) begin
                cov_misses++;
                $display("Jump code %0d was never skipped by any program", c);
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge i_clk);
        i_run <= 1'b0;
        i_rst <= 1'b1;
        repeat (8) @(posedge i_clk);
        i_rst <= 1'b0;
    endtask

    // Unused words hold NOPs tagged with their address
    task automatic load_program();
        for (int a = 0; a < 2**PC_W; a++) begin
            @(posedge i_clk);
            i_imem_we   <= 1'b1;
            i_imem_addr <= PC_W'(a);
            i_imem_data <= (a < prog_len) ? prog[a] : {8'(a), ~8'(a), 16'h0000};
        end
        @(posedge i_clk);
        i_imem_we <= 1'b0;
    endtask

    task automatic run_program(input int prog_no);
        int idx;
        int cycles;
        idx    = 0;
        cycles = 0;
        @(posedge i_clk);
        i_run <= 1'b1;
        while (idx < exp_reg.size()) begin
            @(negedge i_clk);
            cycles++;
            if (cycles > RUN_TIMEOUT) begin
                $display("Timeout: program %0d gave %0d of %0d writebacks",
                         prog_no, idx, exp_reg.size());
                $display("Result: FAILED");
                $finish;
            end else if (o_wb_valid) begin
                check_wb(o_wb_reg, o_wb_data, exp_reg[idx], exp_data[idx]);
                idx++;
            end
        end
        // Core now spins on the closing jump
        repeat (8) begin
            @(negedge i_clk);
            if (o_wb_valid) begin
                wb_errors++;
                $display("Program %0d wrote r%0d after its last expected writeback",
                         prog_no, o_wb_reg);
            end
        end
        check_flags(o_flags, exp_flags, "at program end");
    endtask

    initial begin
        i_rst       <= 1'b1;
        i_run       <= 1'b0;
        i_imem_we   <= 1'b0;
        i_imem_addr <= '0;
        i_imem_data <= '0;
        lcg_state         = 32'h0e1800dc;
        wb_count          = 0;
        wb_errors         = 0;
        flag_errors       = 0;
        cov_misses        = 0;
        jump_taken_seen   = '0;
        jump_skipped_seen = '0;

        for (int p = 0; p < NUM_PROGS; p++) begin
            gen_program();
            run_model();
            apply_reset();
            @(negedge i_clk);
            check_flags(o_flags, 2'b00, "after reset");
            load_program();
            run_program(p);
        end
        check_jump_coverage();

        $display("Programs %0d, writebacks %0d, wb errors %0d, flag errors %0d, %s %0d",
                 NUM_PROGS, wb_count, wb_errors, flag_errors, "jump coverage misses",
                 cov_misses);
        if (wb_errors == 0 && flag_errors == 0 && cov_misses == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpu_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_run,
    input  logic                 i_imem_we,
    input  logic [PC_W-1:0]      i_imem_addr,
    input  logic [I_SIZE-1:0]    i_imem_data,
    output logic                 o_wb_valid,
    output logic [REGNO_LOG-1:0] o_wb_reg,
    output logic [DATA_W-1:0]    o_wb_data,
    output logic [1:0]           o_flags
);

    // Fetch to decode
    logic                   f_submit;
    logic [INSTR_L_W-1:0]   f_instr_l;
    logic [IMM_W-1:0]       f_imm;
    logic                   d_ready;

    // Decode to execute
    logic                   d_submit;
    logic [IMM_W-1:0]       d_imm;
    logic                   d_pc_inc;
    logic                   d_pc_ie;
    logic                   d_r_bus_imm;
    logic [ALU_MODE_W-1:0]  d_alu_mode;
    logic                   d_alu_carry_en;
    logic                   d_alu_flags_ie;
    logic [REGNO_LOG-1:0]   d_l_reg_sel;
    logic [REGNO_LOG-1:0]   d_r_reg_sel;
    logic [REGNO-1:0]       d_rf_ie;
    logic [JUMP_CODE_W-1:0] d_jump_cond_code;
    logic                   x_ready;

    logic                   redirect;
    logic [PC_W-1:0]        target;

    cpu_fetch u_fetch (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_run       (i_run),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .i_ready     (d_ready),
        .i_redirect  (redirect),
        .i_target    (target),
        .o_submit    (f_submit),
        .o_instr_l   (f_instr_l),
        .o_imm       (f_imm)
    );

    cpu_decode u_decode (
        .i_clk             (i_clk),
        .i_rst             (i_rst),
        .i_flush           (redirect),
        .i_instr_l         (f_instr_l),
        .i_imm_pass        (f_imm),
        .o_imm_pass        (d_imm),
        .i_next_ready      (x_ready),
        .i_submit          (f_submit),
        .o_ready           (d_ready),
        .o_submit          (d_submit),
        .oc_pc_inc         (d_pc_inc),
        .oc_pc_ie          (d_pc_ie),
        .oc_r_bus_imm      (d_r_bus_imm),
        .oc_alu_mode       (d_alu_mode),
        .oc_alu_carry_en   (d_alu_carry_en),
        .oc_alu_flags_ie   (d_alu_flags_ie),
        .oc_l_reg_sel      (d_l_reg_sel),
        .oc_r_reg_sel      (d_r_reg_sel),
        .oc_rf_ie          (d_rf_ie),
        .oc_jump_cond_code (d_jump_cond_code)
    );

    cpu_execute u_execute (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_submit         (d_submit),
        .i_pc_inc         (d_pc_inc),
        .i_pc_ie          (d_pc_ie),
        .i_r_bus_imm      (d_r_bus_imm),
        .i_alu_mode       (d_alu_mode),
        .i_alu_carry_en   (d_alu_carry_en),
        .i_alu_flags_ie   (d_alu_flags_ie),
        .i_l_reg_sel      (d_l_reg_sel),
        .i_r_reg_sel      (d_r_reg_sel),
        .i_rf_ie          (d_rf_ie),
        .i_jump_cond_code (d_jump_cond_code),
        .i_imm            (d_imm),
        .o_ready          (x_ready),
        .o_redirect       (redirect),
        .o_target         (target),
        .o_wb_valid       (o_wb_valid),
        .o_wb_reg         (o_wb_reg),
        .o_wb_data        (o_wb_data),
        .o_flags          (o_flags)
    );

endmodule

`default_nettype wire

// ==== cpu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_execute import cpu_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_submit,

    input  logic                   i_pc_inc,
    input  logic                   i_pc_ie,
    input  logic                   i_r_bus_imm,
    input  logic [ALU_MODE_W-1:0]  i_alu_mode,
    input  logic                   i_alu_carry_en,
    input  logic                   i_alu_flags_ie,
    input  logic [REGNO_LOG-1:0]   i_l_reg_sel,
    input  logic [REGNO_LOG-1:0]   i_r_reg_sel,
    input  logic [REGNO-1:0]       i_rf_ie,
    input  logic [JUMP_CODE_W-1:0] i_jump_cond_code,
    input  logic [IMM_W-1:0]       i_imm,

    output logic                   o_ready,
    output logic                   o_redirect,
    output logic [PC_W-1:0]        o_target,
    output logic                   o_wb_valid,
    output logic [REGNO_LOG-1:0]   o_wb_reg,
    output logic [DATA_W-1:0]      o_wb_data,
    output logic [1:0]             o_flags
);

    logic [REGNO-1:0]  we;
    logic [DATA_W-1:0] l_data;
    logic [DATA_W-1:0] r_data;
    logic [DATA_W-1:0] r_bus;
    logic [DATA_W-1:0] result;
    logic              alu_carry;
    logic              alu_zero;
    logic              flag_c;
    logic              flag_z;
    logic              cond_met;
    logic              is_jump;

    assign we    = i_submit ? i_rf_ie : '0;
    assign r_bus = i_r_bus_imm ? i_imm : r_data;

    cpu_regfile u_regfile (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_we     (we),
        .i_wdata  (result),
        .i_l_sel  (i_l_reg_sel),
        .i_r_sel  (i_r_reg_sel),
        .o_l_data (l_data),
        .o_r_data (r_data)
    );

    cpu_alu u_alu (
        .i_mode   (i_alu_mode),
        .i_l      (l_data),
        .i_r      (r_bus),
        .i_carry  (i_alu_carry_en && flag_c),
        .o_result (result),
        .o_carry  (alu_carry),
        .o_zero   (alu_zero)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            flag_c <= 1'b0;
            flag_z <= 1'b0;
        end else if (i_submit && i_alu_flags_ie) begin
            flag_c <= alu_carry;
            flag_z <= alu_zero;
        end
    end

    always_comb begin
        case (i_jump_cond_code[JUMP_CODE_W-2:0])
            JC_ALWAYS: cond_met = 1'b1;
            JC_Z:      cond_met = flag_z;
            JC_NZ:     cond_met = !flag_z;
            JC_C:      cond_met = flag_c;
            JC_NC:     cond_met = !flag_c;
            default:   cond_met = 1'b0;
        endcase
    end

    // Jumps do not increment, pc_ie forces a load regardless of condition
    assign is_jump    = i_jump_cond_code[JUMP_CODE_W-1] && !i_pc_inc;
    assign o_redirect = i_submit && (i_pc_ie || (is_jump && cond_met));
    assign o_target   = result[PC_W-1:0];

    always_comb begin
        o_wb_reg = '0;
        for (int i = 0; i < REGNO; i++) begin
            if (i_rf_ie[i]) begin
                o_wb_reg = REGNO_LOG'(i);
            end
        end
    end

    assign o_wb_valid = |we;
    assign o_wb_data  = result;
    assign o_flags    = {flag_c, flag_z};
    assign o_ready    = 1'b1;

endmodule

`default_nettype wire

// ==== cpu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_decode import cpu_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_flush,

    input  logic [INSTR_L_W-1:0]   i_instr_l,
    input  logic [IMM_W-1:0]       i_imm_pass,
    output logic [IMM_W-1:0]       o_imm_pass,

    input  logic                   i_next_ready,
    input  logic                   i_submit,
    output logic                   o_ready,
    output logic                   o_submit,

    output logic                   oc_pc_inc,
    output logic                   oc_pc_ie,
    output logic                   oc_r_bus_imm,
    output logic [ALU_MODE_W-1:0]  oc_alu_mode,
    output logic                   oc_alu_carry_en,
    output logic                   oc_alu_flags_ie,
    output logic [REGNO_LOG-1:0]   oc_l_reg_sel,
    output logic [REGNO_LOG-1:0]   oc_r_reg_sel,
    output logic [REGNO-1:0]       oc_rf_ie,
    output logic [JUMP_CODE_W-1:0] oc_jump_cond_code
);

    logic                   buf_valid;
    logic [INSTR_L_W-1:0]   buf_instr_l;
    logic [IMM_W-1:0]       buf_imm;
    logic                   take_in;
    logic                   have_item;
    logic                   issue;
    logic [INSTR_L_W-1:0]   instr;
    logic [OPC_W-1:0]       opcode;
    logic [REGNO_LOG-1:0]   reg_dst;
    logic [REGNO_LOG-1:0]   reg_st;
    logic [REGNO_LOG-1:0]   reg_nd;

    logic                   c_pc_inc;
    logic                   c_pc_ie;
    logic                   c_r_bus_imm;
    logic [ALU_MODE_W-1:0]  c_alu_mode;
    logic                   c_alu_carry_en;
    logic                   c_alu_flags_ie;
    logic [REGNO_LOG-1:0]   c_l_reg_sel;
    logic [REGNO_LOG-1:0]   c_r_reg_sel;
    logic [REGNO-1:0]       c_rf_ie;
    logic [JUMP_CODE_W-1:0] c_jump_cond_code;

    assign take_in   = i_submit && o_ready;
    assign have_item = buf_valid || take_in;
    assign issue     = have_item && i_next_ready;

    // Buffered item goes first
    assign instr   = buf_valid ? buf_instr_l : i_instr_l;
    assign opcode  = instr[6:0];
    assign reg_dst = instr[9:7];
    assign reg_st  = instr[12:10];
    assign reg_nd  = instr[15:13];

    always_comb begin
        c_pc_inc         = 1'b1;
        c_pc_ie          = 1'b0;
        c_r_bus_imm      = 1'b0;
        c_alu_carry_en   = 1'b0;
        c_alu_flags_ie   = 1'b0;
        c_rf_ie          = '0;
        c_alu_mode       = ALU_MODE_L_PASS;
        c_l_reg_sel      = '0;
        c_r_reg_sel      = '0;
        c_jump_cond_code = '0;

        case (opcode)
            OPC_MOV: begin
                c_l_reg_sel      = reg_st;
                c_rf_ie[reg_dst] = 1'b1;
            end
            OPC_LDI: begin
                c_alu_mode       = ALU_MODE_R_PASS;
                c_r_bus_imm      = 1'b1;
                c_rf_ie[reg_dst] = 1'b1;
            end
            OPC_ADD, OPC_ADC: begin
                c_alu_mode       = ALU_MODE_ADD;
                c_l_reg_sel      = reg_st;
                c_r_reg_sel      = reg_nd;
                c_alu_carry_en   = (opcode == OPC_ADC);
                c_rf_ie[reg_dst] = 1'b1;
                c_alu_flags_ie   = 1'b1;
            end
            OPC_ADI: begin
                c_alu_mode       = ALU_MODE_ADD;
                c_l_reg_sel      = reg_st;
                c_r_bus_imm      = 1'b1;
                c_rf_ie[reg_dst] = 1'b1;
                c_alu_flags_ie   = 1'b1;
            end
            OPC_SUB: begin
                c_alu_mode       = ALU_MODE_SUB;
                c_l_reg_sel      = reg_st;
                c_r_reg_sel      = reg_nd;
                c_rf_ie[reg_dst] = 1'b1;
                c_alu_flags_ie   = 1'b1;
            end
            OPC_SUC: begin
                // Subtract immediate with borrow, flags only
                c_alu_mode       = ALU_MODE_SUB;
                c_l_reg_sel      = reg_st;
                c_r_reg_sel      = reg_nd;
                c_r_bus_imm      = 1'b1;
                c_alu_carry_en   = 1'b1;
                c_alu_flags_ie   = 1'b1;
            end
            OPC_CMP, OPC_CMI: begin
                c_alu_mode       = ALU_MODE_SUB;
                c_l_reg_sel      = reg_st;
                c_r_reg_sel      = reg_nd;
                c_r_bus_imm      = (opcode == OPC_CMI);
                c_alu_flags_ie   = 1'b1;
            end
            OPC_JMP: begin
                // Condition is resolved in execute against the live flags
                c_pc_inc         = 1'b0;
                c_alu_mode       = ALU_MODE_R_PASS;
                c_r_bus_imm      = 1'b1;
                c_jump_cond_code = {1'b1, instr[10:7]};
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst || i_flush) begin
            o_submit  <= 1'b0;
            o_ready   <= 1'b1;
            buf_valid <= 1'b0;
        end else begin
            o_submit  <= issue;
            // Hold the item and stop the upstream until execute takes it
            buf_valid <= have_item && !i_next_ready;
            o_ready   <= !(have_item && !i_next_ready);
        end
    end

    always_ff @(posedge i_clk) begin
        if (take_in) begin
            buf_instr_l <= i_instr_l;
            buf_imm     <= i_imm_pass;
        end
        if (issue) begin
            o_imm_pass        <= buf_valid ? buf_imm : i_imm_pass;
            oc_pc_inc         <= c_pc_inc;
            oc_pc_ie          <= c_pc_ie;
            oc_r_bus_imm      <= c_r_bus_imm;
            oc_alu_mode       <= c_alu_mode;
            oc_alu_carry_en   <= c_alu_carry_en;
            oc_alu_flags_ie   <= c_alu_flags_ie;
            oc_l_reg_sel      <= c_l_reg_sel;
            oc_r_reg_sel      <= c_r_reg_sel;
            oc_rf_ie          <= c_rf_ie;
            oc_jump_cond_code <= c_jump_cond_code;
        end
    end

endmodule

`default_nettype wire

// ==== cpu_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_fetch import cpu_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_run,

    // Program load port
    input  logic                 i_imem_we,
    input  logic [PC_W-1:0]      i_imem_addr,
    input  logic [I_SIZE-1:0]    i_imem_data,

    input  logic                 i_ready,
    input  logic                 i_redirect,
    input  logic [PC_W-1:0]      i_target,

    output logic                 o_submit,
    output logic [INSTR_L_W-1:0] o_instr_l,
    output logic [IMM_W-1:0]     o_imm
);

    logic [I_SIZE-1:0] imem [2**PC_W];
    logic [PC_W-1:0]   pc;
    logic              fetch_en;

    // Fetch when the output slot is free or being taken this cycle
    assign fetch_en = i_run && !i_redirect && (!o_submit || i_ready);

    always_ff @(posedge i_clk) begin
        if (i_imem_we && !i_run) begin
            imem[i_imem_addr] <= i_imem_data;
        end
        if (fetch_en) begin
            {o_imm, o_instr_l} <= imem[pc];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc       <= '0;
            o_submit <= 1'b0;
        end else if (i_redirect) begin
            // Wrong-path word is dropped
            pc       <= i_target;
            o_submit <= 1'b0;
        end else if (fetch_en) begin
            pc       <= pc + 1'b1;
            o_submit <= 1'b1;
        end else if (o_submit && i_ready) begin
            o_submit <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== cpu_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile import cpu_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic [REGNO-1:0]     i_we,
    input  logic [DATA_W-1:0]    i_wdata,
    input  logic [REGNO_LOG-1:0] i_l_sel,
    input  logic [REGNO_LOG-1:0] i_r_sel,
    output logic [DATA_W-1:0]    o_l_data,
    output logic [DATA_W-1:0]    o_r_data
);

    logic [DATA_W-1:0] regs [REGNO];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < REGNO; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < REGNO; i++) begin
                if (i_we[i]) begin
                    regs[i] <= i_wdata;
                end
            end
        end
    end

    // Combinational reads
    assign o_l_data = regs[i_l_sel];
    assign o_r_data = regs[i_r_sel];

endmodule

`default_nettype wire

// ==== cpu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_alu import cpu_pkg::*; (
    input  logic [ALU_MODE_W-1:0] i_mode,
    input  logic [DATA_W-1:0]     i_l,
    input  logic [DATA_W-1:0]     i_r,
    input  logic                  i_carry,
    output logic [DATA_W-1:0]     o_result,
    output logic                  o_carry,
    output logic                  o_zero
);

    logic [DATA_W:0] wide;

    always_comb begin
        wide = '0;
        case (i_mode)
            ALU_MODE_L_PASS: begin
                wide = {1'b0, i_l};
            end
            ALU_MODE_R_PASS: begin
                wide = {1'b0, i_r};
            end
            ALU_MODE_ADD: begin
                wide = {1'b0, i_l} + {1'b0, i_r} + {{DATA_W{1'b0}}, i_carry};
            end
            ALU_MODE_SUB: begin
                // Top bit ends up as the borrow
                wide = {1'b0, i_l} - {1'b0, i_r} - {{DATA_W{1'b0}}, i_carry};
            end
            default: begin
                wide = '0;
            end
        endcase
    end

    assign o_result = wide[DATA_W-1:0];
    assign o_carry  = wide[DATA_W];
    assign o_zero   = (wide[DATA_W-1:0] == '0);

endmodule

`default_nettype wire

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // Instruction layout, low half holds opcode and register fields
    localparam int I_SIZE    = 32;
    localparam int IMM_W     = 16;
    localparam int INSTR_L_W = I_SIZE - IMM_W;

    // Datapath
    localparam int DATA_W    = 16;
    localparam int REGNO     = 8;
    localparam int REGNO_LOG = 3;
    localparam int PC_W      = 8;

    // ALU modes
    localparam int ALU_MODE_W = 2;
    localparam logic [ALU_MODE_W-1:0] ALU_MODE_L_PASS = 2'd0;
    localparam logic [ALU_MODE_W-1:0] ALU_MODE_R_PASS = 2'd1;
    localparam logic [ALU_MODE_W-1:0] ALU_MODE_ADD    = 2'd2;
    localparam logic [ALU_MODE_W-1:0] ALU_MODE_SUB    = 2'd3;

    // Jump code is {is_jump, condition}
    localparam int JUMP_CODE_W = 5;
    localparam logic [JUMP_CODE_W-2:0] JC_ALWAYS = 4'd0;
    localparam logic [JUMP_CODE_W-2:0] JC_Z      = 4'd1;
    localparam logic [JUMP_CODE_W-2:0] JC_NZ     = 4'd2;
    localparam logic [JUMP_CODE_W-2:0] JC_C      = 4'd3;
    localparam logic [JUMP_CODE_W-2:0] JC_NC     = 4'd4;

    // Opcodes
    localparam int OPC_W = 7;
    localparam logic [OPC_W-1:0] OPC_NOP = 7'h00;
    localparam logic [OPC_W-1:0] OPC_MOV = 7'h01;
    localparam logic [OPC_W-1:0] OPC_LDI = 7'h04;
    localparam logic [OPC_W-1:0] OPC_ADD = 7'h07;
    localparam logic [OPC_W-1:0] OPC_ADI = 7'h08;
    localparam logic [OPC_W-1:0] OPC_ADC = 7'h09;
    localparam logic [OPC_W-1:0] OPC_SUB = 7'h0a;
    localparam logic [OPC_W-1:0] OPC_SUC = 7'h0b;
    localparam logic [OPC_W-1:0] OPC_CMP = 7'h0c;
    localparam logic [OPC_W-1:0] OPC_CMI = 7'h0d;
    localparam logic [OPC_W-1:0] OPC_JMP = 7'h0e;

endpackage

`default_nettype wire
